//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP = tb_cache
FILELIST = files.f
BUILD = obj_dir
LOG = sim.log
PASS_MSG = Test passed

all: run

$(BUILD)/V$(TOP): $(wildcard *.sv) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

.PHONY: all run lint clean

//--- cache_checker.sv
`timescale 1ns/100ps

module cache_checker (
	input logic clk,
	input logic rst,
	input logic mem_read,
	input logic mem_write,
	input logic cpu_rdvalid,
	input logic cpu_ready
);

	one_mem_command: assert property (@(posedge clk) disable iff (rst)
		!(mem_read && mem_write))
		else $error("mem_read and mem_write are high in the same cycle");

	// the read strobe is a single-cycle pulse
	rdvalid_pulse: assert property (@(posedge clk) disable iff (rst)
		cpu_rdvalid |=> !cpu_rdvalid)
		else $error("cpu_rdvalid stayed high for two cycles");

	busy_during_mem: assert property (@(posedge clk) disable iff (rst)
		(mem_read || mem_write) |-> !cpu_ready)
		else $error("cpu_ready is high while a memory command is pending");

endmodule

bind cache_top cache_checker checker_i (
	.clk(clk),
	.rst(rst),
	.mem_read(mem_read),
	.mem_write(mem_write),
	.cpu_rdvalid(cpu_rdvalid),
	.cpu_ready(cpu_ready)
);

//--- cache_ctrl.sv
`timescale 1ns/100ps

module cache_ctrl import cache_pkg::*; (
	input logic clk,
	input logic rst,
	input logic cpu_read,
	input logic cpu_write,
	input logic mem_ready,
	input logic mem_rdvalid,
	input line_t mem_rddata,
	req_if.sink req,
	line_if.ctrl line,
	output logic idle,
	output logic rd_start,
	output logic wr_start,
	output logic victim_sel,
	output logic cpu_rdvalid
);

	logic [state_w-1:0] state;
	logic [state_w-1:0] state_nxt;
	logic fill_got;
	logic need_wb;

	assign need_wb = line.victim_valid && (req.policy == policy_wb);
	assign idle = (state == st_idle);
	assign line.array_we = (state == st_fill) || (state == st_merge);
	assign line.fill_sel = (state == st_fill);

	always_comb begin
		state_nxt = state;
		rd_start = 1'b0;
		wr_start = 1'b0;
		victim_sel = 1'b0;
		case (state)
			st_idle:
				if (cpu_read || cpu_write)
					state_nxt = st_lookup;
			st_lookup:
				state_nxt = st_compare; // array read of the held index lands here
			st_compare:
				if (line.hit_valid) begin
					if (line.hit && req.rd) begin
						state_nxt = st_respond;
					end else if (line.hit && req.wr) begin
						state_nxt = st_merge;
					end else if (line.hit) begin
						state_nxt = st_idle;
					end else if (need_wb) begin
						wr_start = 1'b1;
						victim_sel = 1'b1;
						state_nxt = st_wb;
					end else begin
						rd_start = 1'b1;
						state_nxt = st_rd_req;
					end
				end
			st_respond:
				state_nxt = st_idle;
			st_wb:
				if (mem_ready) begin // victim is out, fetch the new line
					rd_start = 1'b1;
					state_nxt = st_rd_req;
				end
			st_rd_req:
				if (mem_ready)
					state_nxt = st_rd_data;
			st_rd_data:
				if (fill_got || mem_rdvalid)
					state_nxt = st_fill;
			st_fill:
				state_nxt = st_lookup; // look the set up again after the fill
			st_merge:
				if (req.policy == policy_wt) begin
					wr_start = 1'b1;
					state_nxt = st_wt;
				end else begin
					state_nxt = st_idle;
				end
			st_wt:
				if (mem_ready)
					state_nxt = st_idle;
			default:
				state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			fill_got <= 1'b0;
			cpu_rdvalid <= 1'b0;
		end else begin
			state <= state_nxt;
			cpu_rdvalid <= (state == st_respond);
			if (rd_start)
				fill_got <= 1'b0;
			else if (mem_rdvalid)
				fill_got <= 1'b1; // data may come back before mem_read drops
		end
	end

	always_ff @(posedge clk) begin
		if (mem_rdvalid)
			line.fill_line <= mem_rddata;
	end

endmodule

//--- cache_if.sv
`timescale 1ns/100ps

interface req_if import cache_pkg::*; ();
	logic rd;
	logic wr;
	cache_addr_u addr;
	logic [cpu_w-1:0] wrdata;
	logic [strb_w-1:0] wrstrb;
	policy_t policy;

	modport source (output rd, wr, addr, wrdata, wrstrb, policy);
	modport sink (input rd, wr, addr, wrdata, wrstrb, policy);
endinterface

interface line_if import cache_pkg::*; ();
	logic hit;
	logic hit_valid; // array read matches the held index and is not stale
	logic victim_valid;
	logic [tag_bits-1:0] victim_tag;
	line_t victim_line;
	line_t merged_line;
	logic [cpu_w-1:0] rd_word;
	logic array_we;
	logic fill_sel;
	line_t fill_line;

	modport store (
		output hit, hit_valid, victim_valid, victim_tag, victim_line, merged_line, rd_word,
		input array_we, fill_sel, fill_line
	);
	modport ctrl (
		input hit, hit_valid, victim_valid,
		output array_we, fill_sel, fill_line
	);
endinterface

//--- cache_pkg.sv
package cache_pkg;

	localparam int addr_w = 32;
	localparam int cpu_w = 32;
	localparam int strb_w = cpu_w / 8;
	localparam int line_w = 128;
	localparam int words_per_line = line_w / cpu_w;
	localparam int ways = 2;
	localparam int sets = 8;
	localparam int byte_bits = 2;
	localparam int word_bits = 2;
	localparam int index_bits = 3;
	localparam int tag_bits = addr_w - index_bits - word_bits - byte_bits;
	localparam int lru_w = 2; // holds the value ways after a fill

	typedef logic [line_w-1:0] line_t;
	typedef logic [4:0] policy_t;

	localparam policy_t policy_wt = 5'd1;
	localparam policy_t policy_wb = 5'd2;
	localparam policy_t policy_reset = policy_wt;
	localparam logic [addr_w-1:0] cfg_policy_addr = 32'd0;

	// the same word seen as a bus address or as cache fields
	typedef union packed {
		logic [addr_w-1:0] flat;
		struct packed {
			logic [tag_bits-1:0] tag;
			logic [index_bits-1:0] index;
			logic [word_bits-1:0] word;
			logic [byte_bits-1:0] byte_sel;
		} f;
	} cache_addr_u;

	localparam int state_w = 4;
	localparam logic [state_w-1:0] st_idle = 4'd0;
	localparam logic [state_w-1:0] st_lookup = 4'd1;
	localparam logic [state_w-1:0] st_compare = 4'd2;
	localparam logic [state_w-1:0] st_respond = 4'd3;
	localparam logic [state_w-1:0] st_wb = 4'd4;
	localparam logic [state_w-1:0] st_rd_req = 4'd5;
	localparam logic [state_w-1:0] st_rd_data = 4'd6;
	localparam logic [state_w-1:0] st_fill = 4'd7;
	localparam logic [state_w-1:0] st_merge = 4'd8;
	localparam logic [state_w-1:0] st_wt = 4'd9;

endpackage

//--- cache_store.sv
`timescale 1ns/100ps

module cache_store import cache_pkg::*; (
	input logic clk,
	input logic rst,
	req_if.sink req,
	line_if.store line
);

	logic [ways-1:0][tag_bits-1:0] tag_arr [sets];
	logic [ways-1:0][line_w-1:0] data_arr [sets];
	logic [ways-1:0][lru_w-1:0] lru_arr [sets];
	logic [ways-1:0] valid_arr [sets];

	logic [ways-1:0][tag_bits-1:0] tag_q;
	logic [ways-1:0][line_w-1:0] data_q;
	logic [ways-1:0][lru_w-1:0] lru_q;
	logic [ways-1:0] valid_q;
	logic [index_bits-1:0] idx_q;
	logic we_q;
	logic [index_bits-1:0] clr_idx = '0;

	logic [ways-1:0] hit_vec;
	logic [ways-1:0] vict_vec;
	logic [ways-1:0] wr_vec;
	logic [lru_w-1:0] smallest;
	logic any_hit;
	line_t hit_line;
	line_t merged;
	logic [ways-1:0][tag_bits-1:0] new_tag;
	logic [ways-1:0][line_w-1:0] new_data;
	logic [ways-1:0][lru_w-1:0] new_lru;

	always_ff @(posedge clk) begin
		tag_q <= tag_arr[req.addr.f.index];
		data_q <= data_arr[req.addr.f.index];
		lru_q <= lru_arr[req.addr.f.index];
		valid_q <= valid_arr[req.addr.f.index];
		idx_q <= req.addr.f.index;
	end

	always_ff @(posedge clk) begin
		if (rst)
			we_q <= 1'b0;
		else
			we_q <= line.array_we;
	end

	always_ff @(posedge clk) begin
		if (rst)
			clr_idx <= clr_idx + 1'b1; // one set per cycle while rst is held
		else
			clr_idx <= '0;
	end

	assign line.hit_valid = !we_q && (idx_q == req.addr.f.index);

	always_comb begin
		vict_vec = '0;
		vict_vec[0] = 1'b1;
		smallest = lru_q[0];
		for (int w = 1; w < ways; w++) begin
			if (lru_q[w] < smallest) begin // ties keep the lower way
				vict_vec = '0;
				vict_vec[w] = 1'b1;
				smallest = lru_q[w];
			end
		end
	end

	always_comb begin
		hit_line = data_q[0];
		line.victim_line = data_q[0];
		line.victim_tag = tag_q[0];
		line.victim_valid = valid_q[0];
		for (int w = 0; w < ways; w++) begin
			hit_vec[w] = valid_q[w] && (tag_q[w] == req.addr.f.tag);
			if (hit_vec[w])
				hit_line = data_q[w];
			if (vict_vec[w]) begin
				line.victim_line = data_q[w];
				line.victim_tag = tag_q[w];
				line.victim_valid = valid_q[w];
			end
		end
	end

	assign any_hit = |hit_vec;
	assign line.hit = any_hit;

	always_comb begin
		merged = any_hit ? hit_line : line.victim_line;
		line.rd_word = hit_line[cpu_w-1:0];
		for (int i = 0; i < words_per_line; i++) begin
			if (i == int'(req.addr.f.word)) begin
				line.rd_word = hit_line[i*cpu_w +: cpu_w];
				for (int b = 0; b < strb_w; b++)
					if (req.wrstrb[b])
						merged[i*cpu_w + b*8 +: 8] = req.wrdata[b*8 +: 8];
			end
		end
	end

	assign line.merged_line = merged;

	always_comb begin
		wr_vec = any_hit ? hit_vec : vict_vec;
		new_tag = tag_q;
		new_data = data_q;
		new_lru = lru_q;
		for (int w = 0; w < ways; w++) begin
			if (wr_vec[w]) begin
				new_tag[w] = req.addr.f.tag;
				new_data[w] = line.fill_sel ? line.fill_line : merged;
			end
			if (!any_hit) begin // counters only move on an allocation
				if (vict_vec[w])
					new_lru[w] = lru_w'(ways);
				else if (lru_q[w] != '0)
					new_lru[w] = lru_q[w] - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_arr[clr_idx] <= '0;
			lru_arr[clr_idx] <= '0;
		end else if (line.array_we) begin
			tag_arr[req.addr.f.index] <= new_tag;
			data_arr[req.addr.f.index] <= new_data;
			lru_arr[req.addr.f.index] <= new_lru;
			valid_arr[req.addr.f.index] <= valid_q | wr_vec;
		end
	end

endmodule

//--- cache_top.sv
`timescale 1ns/100ps

module cache_top import cache_pkg::*; (
	input logic clk,
	input logic rst,

	input logic config_valid,
	input logic [cpu_w-1:0] config_word,
	input logic [addr_w-1:0] config_addr,

	input logic cpu_read,
	input logic cpu_write,
	input logic [addr_w-1:0] cpu_address,
	input logic [cpu_w-1:0] cpu_wrdata,
	input logic [strb_w-1:0] cpu_wrstrb,
	output logic [cpu_w-1:0] cpu_rddata,
	output logic cpu_rdvalid,
	output logic cpu_ready,

	output logic mem_read,
	output logic mem_write,
	output logic [addr_w-1:0] mem_address,
	output line_t mem_wrdata,
	input line_t mem_rddata,
	input logic mem_rdvalid,
	input logic mem_ready
);

	req_if req ();
	line_if line ();

	logic rd_start;
	logic wr_start;
	logic victim_sel;

	req_capture req_capture_i (
		.clk(clk),
		.rst(rst),
		.cpu_read(cpu_read),
		.cpu_write(cpu_write),
		.cpu_address(cpu_address),
		.cpu_wrdata(cpu_wrdata),
		.cpu_wrstrb(cpu_wrstrb),
		.config_valid(config_valid),
		.config_word(config_word),
		.config_addr(config_addr),
		.idle(cpu_ready),
		.req(req.source)
	);

	cache_store cache_store_i (
		.clk(clk),
		.rst(rst),
		.req(req.sink),
		.line(line.store)
	);

	cache_ctrl cache_ctrl_i (
		.clk(clk),
		.rst(rst),
		.cpu_read(cpu_read),
		.cpu_write(cpu_write),
		.mem_ready(mem_ready),
		.mem_rdvalid(mem_rdvalid),
		.mem_rddata(mem_rddata),
		.req(req.sink),
		.line(line.ctrl),
		.idle(cpu_ready),
		.rd_start(rd_start),
		.wr_start(wr_start),
		.victim_sel(victim_sel),
		.cpu_rdvalid(cpu_rdvalid)
	);

	mem_port mem_port_i (
		.clk(clk),
		.rst(rst),
		.mem_ready(mem_ready),
		.req(req.sink),
		.victim_tag(line.victim_tag),
		.victim_line(line.victim_line),
		.merged_line(line.merged_line),
		.rd_start(rd_start),
		.wr_start(wr_start),
		.victim_sel(victim_sel),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_address(mem_address),
		.mem_wrdata(mem_wrdata)
	);

	assign cpu_rddata = line.rd_word; // word of the hit way at the held offset

endmodule

//--- files.f
cache_pkg.sv
cache_if.sv
req_capture.sv
cache_store.sv
cache_ctrl.sv
mem_port.sv
cache_top.sv
tb_clock.sv
cache_checker.sv
tb_cache.sv

//--- mem_port.sv
`timescale 1ns/100ps

module mem_port import cache_pkg::*; (
	input logic clk,
	input logic rst,
	input logic mem_ready,
	req_if.sink req,
	input logic [tag_bits-1:0] victim_tag,
	input line_t victim_line,
	input line_t merged_line,
	input logic rd_start,
	input logic wr_start,
	input logic victim_sel,
	output logic mem_read,
	output logic mem_write,
	output logic [addr_w-1:0] mem_address,
	output line_t mem_wrdata
);

	cache_addr_u victim_addr;

	always_comb begin
		victim_addr.flat = '0; // victim goes out line aligned
		victim_addr.f.tag = victim_tag;
		victim_addr.f.index = req.addr.f.index;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_read <= 1'b0;
			mem_write <= 1'b0;
		end else begin
			if (rd_start)
				mem_read <= 1'b1;
			else if (mem_ready)
				mem_read <= 1'b0;
			if (wr_start)
				mem_write <= 1'b1;
			else if (mem_ready)
				mem_write <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_start || wr_start) begin
			mem_address <= victim_sel ? victim_addr.flat : req.addr.flat;
			mem_wrdata <= victim_sel ? victim_line : merged_line;
		end
	end

endmodule

//--- req_capture.sv
`timescale 1ns/100ps

module req_capture import cache_pkg::*; (
	input logic clk,
	input logic rst,
	input logic cpu_read,
	input logic cpu_write,
	input logic [addr_w-1:0] cpu_address,
	input logic [cpu_w-1:0] cpu_wrdata,
	input logic [strb_w-1:0] cpu_wrstrb,
	input logic config_valid,
	input logic [cpu_w-1:0] config_word,
	input logic [addr_w-1:0] config_addr,
	input logic idle,
	req_if.source req
);

	always_ff @(posedge clk) begin
		if (rst) begin
			req.rd <= 1'b0;
			req.wr <= 1'b0;
		end else if (idle) begin // the request freezes once the controller leaves idle
			req.rd <= cpu_read;
			req.wr <= cpu_write;
		end
	end

	always_ff @(posedge clk) begin
		if (idle) begin
			req.addr.flat <= cpu_address;
			req.wrdata <= cpu_wrdata;
			req.wrstrb <= cpu_wrstrb;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			req.policy <= policy_reset;
		else if (config_valid && (config_addr == cfg_policy_addr))
			req.policy <= config_word[4:0];
	end

endmodule

//--- tb_cache.sv
`timescale 1ns/100ps

module tb_cache import cache_pkg::*; ();

	localparam int n_ops = 400;
	localparam int mem_lines = 32; // 3 tags per set all land below this
	localparam int tag_pool = 3;
	localparam int clk_ns = 4;
	localparam int line_bytes = line_w / 8;

	logic clk;
	logic rst;
	logic config_valid;
	logic [cpu_w-1:0] config_word;
	logic [addr_w-1:0] config_addr;
	logic cpu_read;
	logic cpu_write;
	logic [addr_w-1:0] cpu_address;
	logic [cpu_w-1:0] cpu_wrdata;
	logic [strb_w-1:0] cpu_wrstrb;
	logic [cpu_w-1:0] cpu_rddata;
	logic cpu_rdvalid;
	logic cpu_ready;
	logic mem_read;
	logic mem_write;
	logic [addr_w-1:0] mem_address;
	line_t mem_wrdata;
	line_t mem_rddata = '0;
	logic mem_rdvalid = 1'b0;
	logic mem_ready = 1'b1;

	integer seed = 16;
	int errors = 0;
	int checks = 0;

	logic [7:0] ref_mem [mem_lines*line_bytes]; // what the CPU should see
	line_t mem_model [mem_lines];
	logic [tag_bits-1:0] tag_m [sets][ways];
	logic valid_m [sets][ways];
	logic next_victim [sets]; // allocation alternates between the two ways of a set
	logic wb_mode;

	logic ev_wr [$];
	logic [addr_w-1:0] ev_addr [$];
	line_t ev_data [$];

	logic ready_next;
	int delay_next;
	int rd_wait;
	int rd_line;
	logic rd_taken;
	logic wr_taken;
	logic rd_pending;
	logic wr_pending;

	tb_clock clk_gen_i (.clk(clk));

	cache_top dut_i (.*);

	function automatic logic [7:0] fill_byte(input int a);
		return 8'((a * 37) ^ (a >> 5) ^ 8'h6b);
	endfunction

	function automatic line_t ref_line(input int ln);
		line_t l;
		for (int b = 0; b < line_bytes; b++)
			l[b*8 +: 8] = ref_mem[ln*line_bytes + b];
		return l;
	endfunction

	task automatic compare(input string what, input line_t got, input line_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic write_config(input logic [addr_w-1:0] addr, input policy_t p);
		@(negedge clk);
		config_valid = 1'b1;
		config_addr = addr;
		config_word = cpu_w'(p);
		@(negedge clk);
		config_valid = 1'b0;
		if (addr == cfg_policy_addr)
			wb_mode = (p == policy_wb);
	endtask

	task automatic run_op(input logic is_wr, input logic [addr_w-1:0] addr,
			input logic [cpu_w-1:0] data, input logic [strb_w-1:0] strb);
		int set;
		int ln;
		int wd;
		int vw;
		int cyc;
		int base;
		logic hit;
		logic done;
		logic [cpu_w-1:0] got_word;
		line_t new_line;
		logic exp_wr [$];
		logic [addr_w-1:0] exp_addr [$];
		line_t exp_data [$];
		set = int'(addr[6:4]);
		ln = int'(addr[addr_w-1:4]);
		wd = int'(addr[3:2]);
		vw = int'(next_victim[set]);
		hit = 1'b0;
		for (int w = 0; w < ways; w++)
			if (valid_m[set][w] && tag_m[set][w] == addr[addr_w-1 -: tag_bits])
				hit = 1'b1;
		new_line = ref_line(ln);
		if (is_wr)
			for (int b = 0; b < strb_w; b++)
				if (strb[b])
					new_line[wd*cpu_w + b*8 +: 8] = data[b*8 +: 8];
		if (!hit && wb_mode && valid_m[set][vw]) begin // valid victim goes out first
			exp_wr.push_back(1'b1);
			exp_addr.push_back({tag_m[set][vw], 3'(set), 4'b0000});
			exp_data.push_back(ref_line(int'({tag_m[set][vw], 3'(set)})));
		end
		if (!hit) begin
			exp_wr.push_back(1'b0);
			exp_addr.push_back(addr);
			exp_data.push_back('0);
		end
		if (is_wr && !wb_mode) begin
			exp_wr.push_back(1'b1);
			exp_addr.push_back(addr);
			exp_data.push_back(new_line);
		end
		base = ev_wr.size();
		@(negedge clk);
		compare("cpu_ready before a request", line_t'(cpu_ready), line_t'(1'b1));
		cpu_read = !is_wr;
		cpu_write = is_wr;
		cpu_address = addr;
		cpu_wrdata = data;
		cpu_wrstrb = strb;
		@(posedge clk);
		cyc = -1; // counts rising edges after the accepting one
		done = 1'b0;
		got_word = '0;
		while (!done) begin
			@(negedge clk);
			cyc++;
			cpu_read = 1'b0;
			cpu_write = 1'b0;
			done = is_wr ? cpu_ready : cpu_rdvalid;
			got_word = cpu_rddata;
		end
		compare("memory transfer count", line_t'(ev_wr.size() - base), line_t'(exp_wr.size()));
		for (int i = 0; i < exp_wr.size() && base + i < ev_wr.size(); i++) begin
			compare("memory transfer kind", line_t'(ev_wr[base+i]), line_t'(exp_wr[i]));
			compare("memory address", line_t'(ev_addr[base+i]), line_t'(exp_addr[i]));
			if (exp_wr[i])
				compare("memory write data", ev_data[base+i], exp_data[i]);
		end
		if (!is_wr) begin
			compare("read data", line_t'(got_word), line_t'(new_line[wd*cpu_w +: cpu_w]));
			if (hit)
				compare("read hit latency", line_t'(cyc), line_t'(3));
		end else if (!wb_mode) begin
			compare("memory word after write-through",
				line_t'(mem_model[ln][wd*cpu_w +: cpu_w]),
				line_t'(new_line[wd*cpu_w +: cpu_w]));
		end
		if (is_wr)
			for (int b = 0; b < strb_w; b++)
				if (strb[b])
					ref_mem[ln*line_bytes + wd*4 + b] = data[b*8 +: 8];
		if (!hit) begin
			tag_m[set][vw] = addr[addr_w-1 -: tag_bits];
			valid_m[set][vw] = 1'b1;
			next_victim[set] = !next_victim[set];
		end
	endtask

	always @(posedge clk) begin
		ready_next = ($unsigned($random(seed)) % 4) != 0; // stall one cycle in four
		delay_next = 1 + int'($unsigned($random(seed)) % 6);
	end

	// behavioral memory, decisions for the next rising edge are made here
	always @(negedge clk) begin
		if (rst) begin
			for (int l = 0; l < mem_lines; l++)
				for (int b = 0; b < line_bytes; b++)
					mem_model[l][b*8 +: 8] = fill_byte(l*line_bytes + b);
			rd_wait = 0;
			rd_taken = 1'b0;
			wr_taken = 1'b0;
			rd_pending = 1'b0;
			wr_pending = 1'b0;
		end else begin
			mem_rdvalid = 1'b0;
			if (rd_wait > 0) begin
				rd_wait--;
				if (rd_wait == 0) begin
					mem_rdvalid = 1'b1;
					mem_rddata = mem_model[rd_line];
				end
			end
			if (rd_pending)
				compare("mem_read during a stall", line_t'(mem_read), line_t'(1'b1));
			if (wr_pending)
				compare("mem_write during a stall", line_t'(mem_write), line_t'(1'b1));
			if (rd_taken)
				compare("mem_read after acceptance", line_t'(mem_read), line_t'(1'b0));
			if (wr_taken)
				compare("mem_write after acceptance", line_t'(mem_write), line_t'(1'b0));
			mem_ready = ready_next;
			rd_taken = mem_read && mem_ready;
			wr_taken = mem_write && mem_ready;
			rd_pending = mem_read && !mem_ready;
			wr_pending = mem_write && !mem_ready;
			if (rd_taken || wr_taken) begin
				if (int'(mem_address[addr_w-1:4]) >= mem_lines) begin
					errors++;
					$display("Memory access to address %0h lies outside the memory model",
						mem_address);
				end else begin
					ev_wr.push_back(wr_taken);
					ev_addr.push_back(mem_address);
					ev_data.push_back(mem_wrdata);
					if (wr_taken) begin
						mem_model[int'(mem_address[addr_w-1:4])] = mem_wrdata;
					end else begin
						rd_line = int'(mem_address[addr_w-1:4]);
						rd_wait = delay_next;
					end
				end
			end
		end
	end

	initial begin
		int tg;
		int idx;
		int wd;
		logic wr;
		logic [cpu_w-1:0] r_data;
		logic [cpu_w-1:0] r_strb;
		rst = 1'b1;
		config_valid = 1'b0;
		config_word = '0;
		config_addr = '0;
		cpu_read = 1'b0;
		cpu_write = 1'b0;
		cpu_address = '0;
		cpu_wrdata = '0;
		cpu_wrstrb = '0;
		wb_mode = 1'b0;
		for (int i = 0; i < mem_lines*line_bytes; i++)
			ref_mem[i] = fill_byte(i);
		for (int s = 0; s < sets; s++) begin
			next_victim[s] = 1'b0;
			for (int w = 0; w < ways; w++) begin
				valid_m[s][w] = 1'b0;
				tag_m[s][w] = '0;
			end
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		compare("cpu_ready after reset", line_t'(cpu_ready), line_t'(1'b1));
		compare("mem_read after reset", line_t'(mem_read), line_t'(1'b0));
		compare("mem_write after reset", line_t'(mem_write), line_t'(1'b0));
		compare("cpu_rdvalid after reset", line_t'(cpu_rdvalid), line_t'(1'b0));
		for (int n = 0; n < n_ops; n++) begin
			if (n == n_ops / 2) begin
				write_config(32'd4, policy_wb); // not the policy address, so no effect
				write_config(cfg_policy_addr, policy_wb);
			end
			tg = int'($unsigned($random(seed)) % tag_pool);
			idx = int'($unsigned($random(seed)) % sets);
			wd = int'($unsigned($random(seed)) % words_per_line);
			wr = (n != 0) && (($unsigned($random(seed)) % 5) >= 3);
			r_data = $random(seed);
			r_strb = $random(seed);
			run_op(wr, {tag_bits'(tg), index_bits'(idx), word_bits'(wd), byte_bits'(0)},
				r_data, r_strb[strb_w-1:0]);
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		#(n_ops * 200 * clk_ns);
		$display("Watchdog timeout: the run did not finish within %0d ns",
			n_ops * 200 * clk_ns);
		$display("Test failed");
		$finish;
	end

endmodule

//--- tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
	output logic clk
);

	localparam int half_ns = 2; // 4 ns period

	initial begin
		clk = 1'b0;
		forever #half_ns clk = ~clk;
	end

endmodule
